/* common/wr_seq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the DDR3 page write sequencer.
// Holds the encoded command word layout, the step table record and the
// local/memory opcode enums. Modules refer to them as wr_seq_pkg::name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package wr_seq_pkg;

    localparam int CMD_ADDR_BITS  = 15;     // row/column field of a command word
    localparam int BANK_BITS      = 3;      // bank field
    localparam int CMD_PAUSE_BITS = 10;     // pause count, done bit sits just above
    localparam int STEP_ADDR_BITS = 4;      // step table address

    // step that repeats once per extra burst
    localparam logic [STEP_ADDR_BITS-1:0] REPEAT_STEP = 4'd4;

    // 2-bit local step operation
    typedef enum logic [1:0] {
        SEQ_NOP       = 2'd0,
        SEQ_WRITE     = 2'd1,
        SEQ_PRECHARGE = 2'd2,
        SEQ_ACTIVATE  = 2'd3
    } seq_op_e;

    // RAS/CAS/WE as seen by the PHY, positive logic
    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,
        RCW_WRITE     = 3'd3,
        RCW_ACTIVATE  = 3'd4,
        RCW_PRECHARGE = 3'd5
    } mem_rcw_e;

    // one entry of the step table, 13 bits
    typedef struct packed {
        logic       dual_cyc;       // counts as two buffer reads
        logic       buf_pgnext;     // advance external buffer page
        logic       pre_done;       // last step of the sequence
        logic [1:0] pause;          // extra idle cycles for pause words
        seq_op_e    op;             // local operation
        logic       odt;            // ODT on
        logic       sel;            // half-cycle select
        logic       dq_dqs_en;      // drive DQ and DQS
        logic       dqs_toggle;     // toggle DQS pattern
        logic       buf_rd;         // read external buffer
        logic       nop_after;      // NOP slot after the command
    } seq_step_t;

    // encoded command word, 32 bits, msb first
    typedef struct packed {
        logic [CMD_ADDR_BITS-1:0] addr;     // row, column or pause/done
        logic [BANK_BITS-1:0]     bank;
        mem_rcw_e                 rcw;
        logic                     odt_en;
        logic                     cke;
        logic                     sel;
        logic                     dq_en;
        logic                     dqs_en;
        logic                     dqs_toggle;
        logic                     dci;
        logic                     buf_wr;
        logic                     buf_rd;
        logic                     nop;
        logic                     buf_rst;
    } cmd_word_t;

endpackage

/* sequencer/wr_step_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run control and step table for one page write.
// A start strobe launches a walk over the ten-step table; the write step
// repeats once per burst beyond the second. The registered step feeds
// the buffer-read tracker and the command word encoder.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wr_step_sequencer #(
    parameter int NUM_XFER_BITS = 6                         // burst count width
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,        // one-cycle strobe while idle
    input  logic [NUM_XFER_BITS-1:0]              num128_in,    // bursts, 0 means full page
    output wr_seq_pkg::seq_step_t                 step,         // registered table output
    output logic                                  gen_run,
    output logic                                  start_d,      // start delayed one cycle
    output logic [NUM_XFER_BITS:0]                num128_in_latched // loop counter, valid on start_d
);

    localparam logic [wr_seq_pkg::STEP_ADDR_BITS-1:0] LOOP_PREV =
        wr_seq_pkg::REPEAT_STEP - 1'b1;                     // step just before the loop
    localparam logic [wr_seq_pkg::STEP_ADDR_BITS-1:0] LOOP_NEXT =
        wr_seq_pkg::REPEAT_STEP + 1'b1;                     // first step after the loop

    logic [wr_seq_pkg::STEP_ADDR_BITS-1:0] step_addr;       // overruns past 9, stop comes from table
    logic [NUM_XFER_BITS:0]                loop_cnt;        // one extra bit so 64 fits
    logic                                  loop_last;       // at most one burst left
    logic                                  pre_done;
    wr_seq_pkg::seq_step_t                 table_step;

    assign loop_last         = (loop_cnt[NUM_XFER_BITS:1] == '0);
    assign pre_done          = step.pre_done && gen_run;
    assign num128_in_latched = loop_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gen_run <= 1'b0;
            start_d <= 1'b0;
        end else begin
            start_d <= start;
            if (start)
                gen_run <= 1'b1;
            else if (pre_done)
                gen_run <= 1'b0;                            // drop after the last step
        end
    end

    // step address walk
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            step_addr <= '0;
        else if (!start && !gen_run)
            step_addr <= '0;                                // idle, park at activate
        else if ((step_addr == LOOP_PREV) && loop_last)
            step_addr <= LOOP_NEXT;                         // single burst, no loop
        else if ((step_addr != wr_seq_pkg::REPEAT_STEP) || loop_last)
            step_addr <= step_addr + 1'b1;
    end

    // burst loop counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            loop_cnt <= '0;
        else if (start)
            loop_cnt <= {(num128_in == '0), num128_in};     // 0 -> 64
        else if (!gen_run)
            loop_cnt <= '0;
        else if ((step_addr == LOOP_PREV) || (step_addr == wr_seq_pkg::REPEAT_STEP))
            loop_cnt <= loop_cnt - 1'b1;
    end

    // step table
    always_comb begin
        table_step = '0;
        case (step_addr)
            4'd0: begin
                table_step.op = wr_seq_pkg::SEQ_ACTIVATE;
            end
            4'd1: begin                                     // read lead-in, two buffer reads
                table_step.buf_rd   = 1'b1;
                table_step.pause    = 2'd1;
                table_step.dual_cyc = 1'b1;
            end
            4'd2: begin                                     // first write
                table_step.op     = wr_seq_pkg::SEQ_WRITE;
                table_step.buf_rd = 1'b1;
                table_step.sel    = 1'b1;
                table_step.odt    = 1'b1;
            end
            4'd3: begin
                table_step.buf_rd    = 1'b1;
                table_step.dq_dqs_en = 1'b1;
                table_step.odt       = 1'b1;
            end
            4'd4: begin                                     // looping write
                table_step.op         = wr_seq_pkg::SEQ_WRITE;
                table_step.nop_after  = 1'b1;
                table_step.buf_rd     = 1'b1;
                table_step.dqs_toggle = 1'b1;
                table_step.dq_dqs_en  = 1'b1;
                table_step.sel        = 1'b1;
                table_step.odt        = 1'b1;
                table_step.dual_cyc   = 1'b1;
            end
            4'd5: begin                                     // DQS postamble
                table_step.pause      = 2'd2;
                table_step.dqs_toggle = 1'b1;
                table_step.dq_dqs_en  = 1'b1;
                table_step.odt        = 1'b1;
            end
            4'd6: table_step.pause = 2'd2;                  // write recovery
            4'd7: begin
                table_step.op         = wr_seq_pkg::SEQ_PRECHARGE;
                table_step.buf_pgnext = 1'b1;
            end
            4'd8: table_step.pause = 2'd2;
            4'd9: table_step.pre_done = 1'b1;
            default: table_step = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            step <= '0;
        else if (start || gen_run)
            step <= table_step;
        else
            step <= '0;                                     // quiet between runs
    end

endmodule

/* sequencer/buf_read_tracker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffer read bookkeeping for the page write sequencer.
// Loads twice the burst count one cycle after start and counts down on
// each reading step; once exhausted, further reads from the table are cut.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module buf_read_tracker #(
    parameter int NUM_XFER_BITS = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_d,
    input  logic [NUM_XFER_BITS:0] num128_in_latched,   // bursts, already 0 -> 64
    input  wr_seq_pkg::seq_step_t  step,
    output logic                   cut_buf_rd           // suppress surplus reads
);

    logic [NUM_XFER_BITS+1:0] rd_left;                  // reads still owed, up to 128
    logic [NUM_XFER_BITS+1:0] rd_left_next;
    logic [1:0]               rd_dec;
    logic                     next_zero;

    assign rd_dec       = step.dual_cyc ? 2'd2 : 2'd1;
    assign rd_left_next = rd_left - {{NUM_XFER_BITS{1'b0}}, rd_dec};
    assign next_zero    = (rd_left_next == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_left    <= '0;
            cut_buf_rd <= 1'b0;
        end else begin
            if (start_d)
                rd_left <= {num128_in_latched, 1'b0};   // two reads per burst
            else if (step.buf_rd)
                rd_left <= rd_left_next;
            // sticky while read steps keep coming
            cut_buf_rd <= step.buf_rd && (cut_buf_rd || next_zero);
        end
    end

endmodule

/* verilog/cmd_word_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packs sequencer steps into 32-bit encoded command words.
// NOP steps become pause words, others become command words carrying
// row or column. Also produces the write strobe and the done pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_word_encoder #(
    parameter int COLADDR_NUMBER = 10                       // column address bits
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic [wr_seq_pkg::BANK_BITS-1:0]      bank_in,
    input  logic [wr_seq_pkg::CMD_ADDR_BITS-1:0]  row_in,
    input  logic [COLADDR_NUMBER-4:0]             start_col,    // column in 8-beat bursts
    input  logic                                  skip_next_page_in,
    input  wr_seq_pkg::seq_step_t                 step,
    input  logic                                  gen_run,
    input  logic                                  cut_buf_rd,
    output wr_seq_pkg::cmd_word_t                 enc_cmd,
    output logic                                  enc_wr,
    output logic                                  enc_done
);

    logic [wr_seq_pkg::BANK_BITS-1:0]     bank;
    logic [wr_seq_pkg::CMD_ADDR_BITS-1:0] row;
    logic [COLADDR_NUMBER-4:0]            col;              // current burst column
    logic                                 skip_next_page;
    logic                                 gen_run_d;
    logic                                 done;             // pre_done one cycle late
    wr_seq_pkg::mem_rcw_e                 rcw;
    wr_seq_pkg::cmd_word_t                next_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank           <= '0;
            row            <= '0;
            skip_next_page <= 1'b0;
        end else if (start) begin
            bank           <= bank_in;
            row            <= row_in;
            skip_next_page <= skip_next_page_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            col <= '0;
        else if (start)
            col <= start_col;
        else if (step.op == wr_seq_pkg::SEQ_WRITE)
            col <= col + 1'b1;                              // next burst after each write
    end

    always_comb begin
        case (step.op)
            wr_seq_pkg::SEQ_WRITE:     rcw = wr_seq_pkg::RCW_WRITE;
            wr_seq_pkg::SEQ_PRECHARGE: rcw = wr_seq_pkg::RCW_PRECHARGE;
            wr_seq_pkg::SEQ_ACTIVATE:  rcw = wr_seq_pkg::RCW_ACTIVATE;
            default:                   rcw = wr_seq_pkg::RCW_NOP;
        endcase
    end

    always_comb begin
        next_word            = '0;                          // cke, dci, buf_wr stay low
        next_word.bank       = bank;
        next_word.rcw        = rcw;
        next_word.odt_en     = step.odt;
        next_word.sel        = step.sel;
        next_word.dq_en      = step.dq_dqs_en;
        next_word.dqs_en     = step.dq_dqs_en;
        next_word.dqs_toggle = step.dqs_toggle;
        next_word.buf_rd     = step.buf_rd && !cut_buf_rd;
        next_word.buf_rst    = step.buf_pgnext && !skip_next_page;
        if (step.op == wr_seq_pkg::SEQ_NOP) begin           // pause word
            next_word.addr = {{(wr_seq_pkg::CMD_ADDR_BITS - wr_seq_pkg::CMD_PAUSE_BITS - 1){1'b0}},
                              done,
                              {(wr_seq_pkg::CMD_PAUSE_BITS - 2){1'b0}},
                              step.pause};
        end else begin
            next_word.nop = step.nop_after;
            if (step.op == wr_seq_pkg::SEQ_WRITE)
                next_word.addr = {{(wr_seq_pkg::CMD_ADDR_BITS - COLADDR_NUMBER){1'b0}},
                                  col, 3'b000};             // burst-aligned column
            else
                next_word.addr = row;                       // activate / precharge
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gen_run_d <= 1'b0;
            done      <= 1'b0;
            enc_wr    <= 1'b0;
            enc_done  <= 1'b0;
            enc_cmd   <= '0;
        end else begin
            gen_run_d <= gen_run;
            done      <= step.pre_done && gen_run;
            enc_wr    <= gen_run || gen_run_d;              // covers the trailing done word
            enc_done  <= enc_wr && !gen_run_d;
            enc_cmd   <= next_word;
        end
    end

endmodule

/* verilog/linear_wr_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the DDR3 single-page write command generator.
// Pulse start with a request to get a stream of encoded command words
// on enc_cmd/enc_wr, closed by a one-cycle enc_done.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module linear_wr_encoder #(
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [wr_seq_pkg::BANK_BITS-1:0]      bank_in,
    input  logic [wr_seq_pkg::CMD_ADDR_BITS-1:0]  row_in,
    input  logic [COLADDR_NUMBER-4:0]             start_col,
    input  logic [NUM_XFER_BITS-1:0]              num128_in,    // 0 means 64 bursts
    input  logic                                  skip_next_page_in,
    input  logic                                  start,
    output wr_seq_pkg::cmd_word_t                 enc_cmd,
    output logic                                  enc_wr,
    output logic                                  enc_done
);

    wr_seq_pkg::seq_step_t  step;
    logic                   gen_run;
    logic                   start_d;
    logic [NUM_XFER_BITS:0] num128_in_latched;
    logic                   cut_buf_rd;

    wr_step_sequencer #(.NUM_XFER_BITS(NUM_XFER_BITS)) wr_step_sequencer_inst (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .num128_in         (num128_in),
        .step              (step),
        .gen_run           (gen_run),
        .start_d           (start_d),
        .num128_in_latched (num128_in_latched)
    );

    buf_read_tracker #(.NUM_XFER_BITS(NUM_XFER_BITS)) buf_read_tracker_inst (
        .clk               (clk),
        .rst               (rst),
        .start_d           (start_d),
        .num128_in_latched (num128_in_latched),
        .step              (step),
        .cut_buf_rd        (cut_buf_rd)
    );

    cmd_word_encoder #(.COLADDR_NUMBER(COLADDR_NUMBER)) cmd_word_encoder_inst (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .skip_next_page_in (skip_next_page_in),
        .step              (step),
        .gen_run           (gen_run),
        .cut_buf_rd        (cut_buf_rd),
        .enc_cmd           (enc_cmd),
        .enc_wr            (enc_wr),
        .enc_done          (enc_done)
    );

endmodule

/* tb/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source.
// Free-running clock, reset high from time zero for a few rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,                        // ns
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst = 1'b1;                                         // async, high from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb/linear_wr_encoder_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the DDR3 page write command generator.
// Runs a table of page requests, collects each word stream and checks
// activate, writes, precharge, buffer reads and the closing done word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module linear_wr_encoder_tb;

    localparam int COLADDR_NUMBER = 10;
    localparam int NUM_XFER_BITS  = 6;
    localparam int WAIT_LIMIT     = 200;                    // cycles per wait loop
    localparam int DONE_BIT       = wr_seq_pkg::CMD_PAUSE_BITS;

    typedef struct packed {
        logic [2:0]  bank;
        logic [14:0] row;
        logic [6:0]  col;
        logic [5:0]  count;                                 // 0 means 64
        logic        skip;
        logic [6:0]  exp_writes;
        logic [6:0]  exp_first_col;
        logic        exp_buf_rst;
    } req_t;

    logic                                 clk;
    logic                                 rst;
    logic [wr_seq_pkg::BANK_BITS-1:0]     bank_in;
    logic [wr_seq_pkg::CMD_ADDR_BITS-1:0] row_in;
    logic [COLADDR_NUMBER-4:0]            start_col;
    logic [NUM_XFER_BITS-1:0]             num128_in;
    logic                                 skip_next_page_in;
    logic                                 start;
    wr_seq_pkg::cmd_word_t                enc_cmd;
    logic                                 enc_wr;
    logic                                 enc_done;

    req_t                  reqs[$];
    wr_seq_pkg::cmd_word_t words[$];                        // one run of enc_wr
    int                    mismatch_cnt = 0;
    int                    timeout_cnt  = 0;
    int                    done_pulses;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) tb_clock_gen_inst (.clk(clk), .rst(rst));

    linear_wr_encoder #(
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS)
    ) linear_wr_encoder_inst (
        .clk (clk), .rst (rst), .bank_in (bank_in), .row_in (row_in), .start_col (start_col),
        .num128_in (num128_in), .skip_next_page_in (skip_next_page_in), .start (start),
        .enc_cmd (enc_cmd), .enc_wr (enc_wr), .enc_done (enc_done)
    );

    function automatic void add_request(input logic [2:0] bank, input logic [14:0] row,
                                        input logic [6:0] col, input logic [5:0] count,
                                        input logic skip, input logic [6:0] exp_writes,
                                        input logic [6:0] exp_first_col, input logic exp_buf_rst);
        req_t r;
        r.bank          = bank;
        r.row           = row;
        r.col           = col;
        r.count         = count;
        r.skip          = skip;
        r.exp_writes    = exp_writes;
        r.exp_first_col = exp_first_col;
        r.exp_buf_rst   = exp_buf_rst;
        reqs.push_back(r);
    endfunction

    task automatic check_word(input string name, input wr_seq_pkg::cmd_word_t exp,
                              input wr_seq_pkg::cmd_word_t act, input wr_seq_pkg::cmd_word_t mask);
        if ((exp & mask) !== (act & mask)) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %h actual %h", name, exp & mask, act & mask);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((enc_wr || enc_done) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (enc_wr || enc_done) begin
            timeout_cnt++;
            $display("timeout: encoder did not go idle");
        end
    endtask

    task automatic issue_request(input req_t r);
        @(posedge clk);
        bank_in           <= r.bank;
        row_in            <= r.row;
        start_col         <= r.col;
        num128_in         <= r.count;
        skip_next_page_in <= r.skip;
        start             <= 1'b1;
        @(posedge clk);
        start             <= 1'b0;                          // one-cycle strobe
    endtask

    task automatic collect_words(input string name);
        int n;
        words.delete();
        done_pulses = 0;
        n = 0;
        @(negedge clk);
        while (!enc_wr && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!enc_wr) begin
            timeout_cnt++;
            $display("timeout in %s: no command words after start", name);
            return;
        end
        n = 0;
        while (enc_wr && n < WAIT_LIMIT) begin
            words.push_back(enc_cmd);
            if (enc_done)
                done_pulses++;                              // done must not overlap words
            @(negedge clk);
            n++;
        end
        if (enc_wr) begin
            timeout_cnt++;
            $display("timeout in %s: word stream did not end", name);
            return;
        end
        n = 0;
        while (!enc_done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!enc_done) begin
            timeout_cnt++;
            $display("timeout in %s: no done pulse", name);
            return;
        end
        check_count({name, " done delay"}, 0, n);           // first cycle with enc_wr low
        repeat (3) begin
            if (enc_done)
                done_pulses++;
            @(negedge clk);
            check_bit({name, " enc_wr after done"}, 1'b0, enc_wr);
        end
        check_count({name, " done pulses"}, 1, done_pulses);
    endtask

    task automatic check_sequence(input string name, input req_t r);
        wr_seq_pkg::cmd_word_t     exp;
        wr_seq_pkg::cmd_word_t     mask;
        wr_seq_pkg::cmd_word_t     w;
        logic [COLADDR_NUMBER-4:0] col;
        int                        writes;
        int                        pre_cnt;
        int                        reads;
        int                        done_words;
        int                        fixed_set;
        if (words.size() == 0)
            return;
        writes = 0;
        pre_cnt = 0;
        reads = 0;
        done_words = 0;
        fixed_set = 0;
        col = r.exp_first_col;
        exp = '0;
        mask = '0;
        exp.rcw  = wr_seq_pkg::RCW_ACTIVATE;
        exp.bank = r.bank;
        exp.addr = r.row;
        mask.rcw  = wr_seq_pkg::mem_rcw_e'(3'b111);
        mask.bank = '1;
        mask.addr = '1;
        check_word({name, " activate"}, exp, words[0], mask);
        foreach (words[i]) begin
            w = words[i];
            if (w.cke || w.dci || w.buf_wr)
                fixed_set++;                                // never driven by this design
            if (w.buf_rd)                                   // weighted read count
                reads += (w.nop || (w.rcw == wr_seq_pkg::RCW_NOP &&
                          w.addr[DONE_BIT-1:0] != '0)) ? 2 : 1;
            exp = '0;
            exp.bank = r.bank;
            if (w.rcw == wr_seq_pkg::RCW_WRITE) begin
                exp.rcw = wr_seq_pkg::RCW_WRITE;
                exp.addr[COLADDR_NUMBER-1:0] = {col, 3'b000};
                check_word($sformatf("%s write %0d", name, writes), exp, w, mask);
                col = col + 1'b1;
                writes++;
            end else if (w.rcw == wr_seq_pkg::RCW_PRECHARGE) begin
                exp.rcw     = wr_seq_pkg::RCW_PRECHARGE;
                exp.addr    = r.row;
                exp.buf_rst = r.exp_buf_rst;
                mask.buf_rst = 1'b1;
                check_word({name, " precharge"}, exp, w, mask);
                mask.buf_rst = 1'b0;
                pre_cnt++;
            end else if (w.rcw == wr_seq_pkg::RCW_NOP && w.addr[DONE_BIT]) begin
                done_words++;
            end
        end
        check_count({name, " writes"}, int'(r.exp_writes), writes);
        check_count({name, " precharges"}, 1, pre_cnt);
        check_count({name, " buffer reads"}, 2 * int'(r.exp_writes), reads);
        check_count({name, " done words"}, 1, done_words);
        check_count({name, " cke/dci/buf_wr words"}, 0, fixed_set);
        exp = '0;
        mask = '0;
        exp.addr[DONE_BIT]  = 1'b1;                         // closing pause word
        mask.addr[DONE_BIT] = 1'b1;
        mask.rcw            = wr_seq_pkg::mem_rcw_e'(3'b111);
        check_word({name, " last word"}, exp, words[words.size()-1], mask);
    endtask

    initial begin
        int    n;
        string name;
        bank_in           = '0;
        row_in            = '0;
        start_col         = '0;
        num128_in         = '0;
        skip_next_page_in = 1'b0;
        start             = 1'b0;
        void'($urandom(32'h79d1_a826));
        //          bank           row             col      count  skip  writes first  buf_rst
        add_request(3'd7,          15'h7fff,       7'd0,    6'd1,  1'b0, 7'd1,  7'd0,   1'b1);
        add_request(3'd0,          15'h0000,       7'd5,    6'd2,  1'b1, 7'd2,  7'd5,   1'b0);
        add_request(3'($urandom), 15'($urandom), 7'd17,   6'd3,  1'b0, 7'd3,  7'd17,  1'b1);
        add_request(3'($urandom), 15'($urandom), 7'd120,  6'd17, 1'b1, 7'd17, 7'd120, 1'b0);
        add_request(3'($urandom), 15'($urandom), 7'd64,   6'd0,  1'b0, 7'd64, 7'd64,  1'b1);
        add_request(3'($urandom), 15'($urandom), 7'd0,    6'd0,  1'b1, 7'd64, 7'd0,   1'b0);
        add_request(3'($urandom), 15'($urandom), 7'd33,   6'd1,  1'b1, 7'd1,  7'd33,  1'b0);
        add_request(3'($urandom), 15'($urandom), 7'd126,  6'd3,  1'b0, 7'd3,  7'd126, 1'b1);
        n = 0;
        @(negedge clk);
        while (rst && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            timeout_cnt++;
            $display("timeout: reset never released");
        end
        check_bit("reset enc_wr", 1'b0, enc_wr);
        check_bit("reset enc_done", 1'b0, enc_done);
        check_word("reset enc_cmd", '0, enc_cmd, '1);
        foreach (reqs[i]) begin
            name = $sformatf("req%0d", i);
            wait_idle();
            issue_request(reqs[i]);
            collect_words(name);
            check_sequence(name, reqs[i]);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* filelist.f */
common/wr_seq_pkg.sv
sequencer/wr_step_sequencer.sv
sequencer/buf_read_tracker.sv
verilog/cmd_word_encoder.sv
verilog/linear_wr_encoder.sv
tb/tb_clock_gen.sv
tb/linear_wr_encoder_tb.sv

/* Bender.yml */
package:
  name: linear_wr_encoder

sources:
  - common/wr_seq_pkg.sv
  - sequencer/wr_step_sequencer.sv
  - sequencer/buf_read_tracker.sv
  - verilog/cmd_word_encoder.sv
  - verilog/linear_wr_encoder.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/linear_wr_encoder_tb.sv
